// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert
TOP ?= hazardCoreTb
FILELIST ?= filelist.f
OBJDIR ?= obj_dir
PASS_MSG ?= All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// ==== filelist.f ====
hazardPkg.sv
stageReg.sv
forwardUnit.sv
stallUnit.sv
hazardCore.sv
hazardCore_checker.sv
hazardCoreTb.sv

// ==== forwardUnit.sv ====
module forwardUnit (
	input hazardPkg::idInfo id,
	input hazardPkg::exTag ex,
	input hazardPkg::memTag mem1,
	input hazardPkg::memTag mem2,
	output hazardPkg::fwdSel fwd
);

	// A stage can supply the operand when it writes a nonzero register equal to src
	function automatic logic writes(
		input logic rfWr,
		input logic [hazardPkg::regAddrW-1:0] dest,
		input logic [hazardPkg::regAddrW-1:0] src
	);
		return rfWr && (dest != '0) && (dest == src);
	endfunction

	// Youngest writer wins
	function automatic logic [1:0] pickSource(
		input logic [hazardPkg::regAddrW-1:0] src,
		input hazardPkg::exTag e,
		input hazardPkg::memTag m1,
		input hazardPkg::memTag m2
	);
		logic [1:0] sel;
		if (writes(e.rfWr, e.dest, src))
			sel = hazardPkg::fwdEx;
		else if (writes(m1.rfWr, m1.dest, src))
			sel = hazardPkg::fwdMem1;
		else if (writes(m2.rfWr, m2.dest, src))
			sel = hazardPkg::fwdMem2;
		else
			sel = hazardPkg::fwdNone;	// Read from register file
		return sel;
	endfunction

	always_comb begin
		fwd.rsSel = pickSource(id.rs, ex, mem1, mem2);
		fwd.rtSel = pickSource(id.rt, ex, mem1, mem2);
	end

endmodule

// ==== hazardCore.sv ====
module hazardCore (
	input logic clk,
	input logic arstN,
	input hazardPkg::idInfo id,
	input hazardPkg::cacheStatus status,
	input hazardPkg::ctrlEvent evt,
	output hazardPkg::fwdSel fwd,
	output hazardPkg::stageWrite wr,
	output logic bubbleSel,
	output logic isStall,
	output logic dcacheStall,
	output logic icacheStall,
	output logic dataOk
);

	hazardPkg::exTag exIn;
	hazardPkg::exTag exQ;
	hazardPkg::memTag mem1In;
	hazardPkg::memTag mem1Q;
	hazardPkg::memTag mem2Q;

	// ID fields that EX keeps track of
	assign exIn.rt = id.rt;
	assign exIn.dest = id.dest;
	assign exIn.rfWr = id.rfWr;
	assign exIn.dmRd = id.dmRd;
	assign exIn.cp0Rd = id.cp0Rd;
	assign exIn.pc = id.pc;

	assign mem1In.rt = exQ.rt;
	assign mem1In.dest = exQ.dest;
	assign mem1In.rfWr = exQ.rfWr;
	assign mem1In.dmRd = exQ.dmRd;
	assign mem1In.cp0Rd = exQ.cp0Rd;
	assign mem1In.pc = exQ.pc;

	stageReg #(.payloadT(hazardPkg::exTag)) exStage (
		.clk(clk),
		.arstN(arstN),
		.load(wr.idExWr),
		.bubble(bubbleSel),	// Stalled ID enters as empty slot
		.d(exIn),
		.q(exQ)
	);

	stageReg #(.payloadT(hazardPkg::memTag)) mem1Stage (
		.clk(clk),
		.arstN(arstN),
		.load(wr.exMem1Wr),
		.bubble(1'b0),
		.d(mem1In),
		.q(mem1Q)
	);

	stageReg #(.payloadT(hazardPkg::memTag)) mem2Stage (
		.clk(clk),
		.arstN(arstN),
		.load(wr.mem1Mem2Wr),
		.bubble(1'b0),
		.d(mem1Q),
		.q(mem2Q)
	);

	forwardUnit i_forwardUnit (
		.id(id),
		.ex(exQ),
		.mem1(mem1Q),
		.mem2(mem2Q),
		.fwd(fwd)
	);

	stallUnit i_stallUnit (
		.id(id),
		.ex(exQ),
		.mem1(mem1Q),
		.mem2(mem2Q),
		.status(status),
		.evt(evt),
		.wr(wr),
		.bubbleSel(bubbleSel),
		.isStall(isStall),
		.dcacheStall(dcacheStall),
		.icacheStall(icacheStall),
		.dataOk(dataOk)
	);

endmodule

// ==== hazardCoreTb.sv ====
module hazardCoreTb;

	typedef struct packed {
		hazardPkg::idInfo id;
		hazardPkg::cacheStatus status;
		hazardPkg::ctrlEvent evt;
		hazardPkg::fwdSel fwd;
		hazardPkg::stageWrite wr;
		logic bubbleSel;
		logic dcacheStall;
		logic icacheStall;
		logic dataOk;
	} testRow;

	logic clk;
	logic arstN;
	hazardPkg::idInfo id;
	hazardPkg::cacheStatus status;
	hazardPkg::ctrlEvent evt;
	hazardPkg::fwdSel fwd;
	hazardPkg::stageWrite wr;
	logic bubbleSel;
	logic isStall;
	logic dcacheStall;
	logic icacheStall;
	logic dataOk;

	testRow rows[$];
	logic tableBuilt;
	int passCount;
	int failCount;

	hazardCore i_hazardCore (
		.clk(clk),
		.arstN(arstN),
		.id(id),
		.status(status),
		.evt(evt),
		.fwd(fwd),
		.wr(wr),
		.bubbleSel(bubbleSel),
		.isStall(isStall),
		.dcacheStall(dcacheStall),
		.icacheStall(icacheStall),
		.dataOk(dataOk)
	);

	bind hazardCore hazardCoreChecker i_checker (
		.clk(clk),
		.arstN(arstN),
		.id(id),
		.evt(evt),
		.fwd(fwd),
		.wr(wr),
		.isStall(isStall),
		.dcacheStall(dcacheStall)
	);

	always #20 clk = ~clk;

	// Flags are {rfWr, dmRd, cp0Rd, bjOp}
	function automatic hazardPkg::idInfo makeId(int rs, int rt, int dest, logic [3:0] flags,
		int pc);
		hazardPkg::idInfo r;
		r.rs = rs[hazardPkg::regAddrW-1:0];
		r.rt = rt[hazardPkg::regAddrW-1:0];
		r.dest = dest[hazardPkg::regAddrW-1:0];
		{r.rfWr, r.dmRd, r.cp0Rd, r.bjOp} = flags;
		r.pc = pc;
		return r;
	endfunction

	task automatic addRow(input hazardPkg::idInfo rowId, input logic [8:0] st,
		input logic [3:0] ev, input logic [1:0] rsExp, input logic [1:0] rtExp,
		input logic [6:0] wrExp, input logic bubbleExp, input logic dcExp, input logic icExp,
		input logic okExp = 1'b1);
		testRow r;
		r.id = rowId;
		r.status = st;
		r.evt = ev;
		r.fwd.rsSel = rsExp;
		r.fwd.rtSel = rtExp;
		r.wr = wrExp;
		r.bubbleSel = bubbleExp;
		r.dcacheStall = dcExp;
		r.icacheStall = icExp;
		r.dataOk = okExp;
		rows.push_back(r);
	endtask

	task automatic checkFwd(input string name, input hazardPkg::fwdSel exp,
		input hazardPkg::fwdSel act);
		if (act !== exp) begin
			$display("FAIL %0t %s expected %b got %b", $time, name, exp, act);
			failCount++;
		end
		else begin
			passCount++;
		end
	endtask

	task automatic checkWrite(input string name, input hazardPkg::stageWrite exp,
		input hazardPkg::stageWrite act);
		if (act !== exp) begin
			$display("FAIL %0t %s expected %b got %b", $time, name, exp, act);
			failCount++;
		end
		else begin
			passCount++;
		end
	endtask

	task automatic checkBit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("FAIL %0t %s expected %b got %b", $time, name, exp, act);
			failCount++;
		end
		else begin
			passCount++;
		end
	endtask

	// Status {iOk, dOk, addrOk, m1Sel, m1En, m2En, m1ValidExc, lastStall, lastConflict}
	task automatic buildTable();
		// Forwarding as writers of r5 move down
		addRow(makeId(1, 2, 5, 4'b1000, 'h100), 9'b111_000_000, 4'b0000,
			hazardPkg::fwdNone, hazardPkg::fwdNone, 7'b1111111, 1'b0, 1'b0, 1'b0);
		addRow(makeId(5, 3, 0, 4'b0000, 'h104), 9'b111_000_000, 4'b0000,
			hazardPkg::fwdEx, hazardPkg::fwdNone, 7'b1111111, 1'b0, 1'b0, 1'b0);
		addRow(makeId(3, 5, 0, 4'b0000, 'h108), 9'b111_000_000, 4'b0000,
			hazardPkg::fwdNone, hazardPkg::fwdMem1, 7'b1111111, 1'b0, 1'b0, 1'b0);
		addRow(makeId(5, 5, 5, 4'b1000, 'h10c), 9'b111_000_000, 4'b0000,
			hazardPkg::fwdMem2, hazardPkg::fwdMem2, 7'b1111111, 1'b0, 1'b0, 1'b0);
		addRow(makeId(5, 5, 5, 4'b1000, 'h110), 9'b111_000_000, 4'b0000,
			hazardPkg::fwdEx, hazardPkg::fwdEx, 7'b1111111, 1'b0, 1'b0, 1'b0);
		addRow(makeId(5, 5, 0, 4'b0000, 'h114), 9'b111_000_000, 4'b0000,
			hazardPkg::fwdEx, hazardPkg::fwdEx, 7'b1111111, 1'b0, 1'b0, 1'b0);	// EX over MEM1
		addRow(makeId(5, 0, 0, 4'b0000, 'h118), 9'b111_000_000, 4'b0000,
			hazardPkg::fwdMem1, hazardPkg::fwdNone, 7'b1111111, 1'b0, 1'b0, 1'b0);
		addRow(makeId(5, 7, 0, 4'b0000, 'h11c), 9'b111_000_000, 4'b0000,
			hazardPkg::fwdMem2, hazardPkg::fwdNone, 7'b1111111, 1'b0, 1'b0, 1'b0);
		addRow(makeId(1, 9, 9, 4'b0000, 'h120), 9'b111_000_000, 4'b0000,
			hazardPkg::fwdNone, hazardPkg::fwdNone, 7'b1111111, 1'b0, 1'b0, 1'b0);
		addRow(makeId(9, 0, 0, 4'b1000, 'h124), 9'b111_000_000, 4'b0000,
			hazardPkg::fwdNone, hazardPkg::fwdNone, 7'b1111111, 1'b0, 1'b0, 1'b0);	// No rfWr
		addRow(makeId(0, 0, 0, 4'b0000, 'h128), 9'b111_000_000, 4'b0000,
			hazardPkg::fwdNone, hazardPkg::fwdNone, 7'b1111111, 1'b0, 1'b0, 1'b0);	// Dest zero
		// Load into r8, then its user
		addRow(makeId(1, 8, 8, 4'b1100, 'h12c), 9'b111_000_000, 4'b0000,
			hazardPkg::fwdNone, hazardPkg::fwdNone, 7'b1111111, 1'b0, 1'b0, 1'b0);
		addRow(makeId(8, 2, 3, 4'b1000, 'h130), 9'b111_000_000, 4'b0000,
			hazardPkg::fwdEx, hazardPkg::fwdNone, 7'b0001111, 1'b1, 1'b0, 1'b1);
		addRow(makeId(8, 2, 3, 4'b1000, 'h130), 9'b111_000_000, 4'b0000,
			hazardPkg::fwdMem1, hazardPkg::fwdNone, 7'b0001111, 1'b1, 1'b0, 1'b1);
		addRow(makeId(8, 2, 3, 4'b1000, 'h130), 9'b111_000_000, 4'b0000,
			hazardPkg::fwdMem2, hazardPkg::fwdNone, 7'b1111111, 1'b0, 1'b0, 1'b0);
		// Branch behind EX writer of r4
		addRow(makeId(0, 4, 4, 4'b1000, 'h134), 9'b111_000_000, 4'b0000,
			hazardPkg::fwdNone, hazardPkg::fwdNone, 7'b1111111, 1'b0, 1'b0, 1'b0);
		addRow(makeId(4, 6, 0, 4'b0001, 'h138), 9'b111_000_000, 4'b0000,
			hazardPkg::fwdEx, hazardPkg::fwdNone, 7'b0001111, 1'b1, 1'b0, 1'b1);
		addRow(makeId(4, 6, 0, 4'b0001, 'h138), 9'b111_000_000, 4'b0000,
			hazardPkg::fwdMem1, hazardPkg::fwdNone, 7'b1111111, 1'b0, 1'b0, 1'b0);
		// Branch meets a load of r10 in MEM2
		addRow(makeId(0, 10, 10, 4'b1100, 'h13c), 9'b111_000_000, 4'b0000,
			hazardPkg::fwdNone, hazardPkg::fwdNone, 7'b1111111, 1'b0, 1'b0, 1'b0);
		addRow(makeId(0, 0, 0, 4'b0000, 'h140), 9'b111_000_000, 4'b0000,
			hazardPkg::fwdNone, hazardPkg::fwdNone, 7'b1111111, 1'b0, 1'b0, 1'b0);
		addRow(makeId(0, 0, 0, 4'b0000, 'h144), 9'b111_000_000, 4'b0000,
			hazardPkg::fwdNone, hazardPkg::fwdNone, 7'b1111111, 1'b0, 1'b0, 1'b0);
		addRow(makeId(10, 0, 0, 4'b0001, 'h148), 9'b111_000_000, 4'b0000,
			hazardPkg::fwdMem2, hazardPkg::fwdNone, 7'b0001111, 1'b1, 1'b0, 1'b1);
		addRow(makeId(10, 0, 0, 4'b0001, 'h148), 9'b111_000_000, 4'b0000,
			hazardPkg::fwdNone, hazardPkg::fwdNone, 7'b1111111, 1'b0, 1'b0, 1'b0);
		// Cache stalls with r11 writer held in EX
		addRow(makeId(0, 11, 11, 4'b1000, 'h14c), 9'b111_000_000, 4'b0000,
			hazardPkg::fwdNone, hazardPkg::fwdNone, 7'b1111111, 1'b0, 1'b0, 1'b0);
		addRow(makeId(11, 0, 0, 4'b0000, 'h150), 9'b101_001_000, 4'b0000,
			hazardPkg::fwdEx, hazardPkg::fwdNone, 7'b0000000, 1'b1, 1'b1, 1'b0, 1'b0);
		addRow(makeId(11, 0, 0, 4'b0000, 'h150), 9'b110_010_000, 4'b0000,
			hazardPkg::fwdEx, hazardPkg::fwdNone, 7'b0000000, 1'b1, 1'b1, 1'b0);
		addRow(makeId(11, 0, 0, 4'b0000, 'h150), 9'b011_000_000, 4'b0000,
			hazardPkg::fwdEx, hazardPkg::fwdNone, 7'b0000000, 1'b1, 1'b1, 1'b0);
		addRow(makeId(11, 0, 0, 4'b0000, 'h150), 9'b110_110_000, 4'b0000,
			hazardPkg::fwdEx, hazardPkg::fwdNone, 7'b1111111, 1'b0, 1'b0, 1'b0);
		addRow(makeId(11, 0, 0, 4'b0000, 'h154), 9'b111_000_101, 4'b0000,
			hazardPkg::fwdMem1, hazardPkg::fwdNone, 7'b1111111, 1'b0, 1'b0, 1'b1);
		addRow(makeId(11, 0, 0, 4'b0000, 'h158), 9'b111_001_010, 4'b0000,
			hazardPkg::fwdMem2, hazardPkg::fwdNone, 7'b1111111, 1'b0, 1'b0, 1'b1);
		// Multiply/divide busy
		addRow(makeId(1, 2, 0, 4'b0000, 'h15c), 9'b111_000_000, 4'b0011,
			hazardPkg::fwdNone, hazardPkg::fwdNone, 7'b0001111, 1'b1, 1'b0, 1'b1);
		addRow(makeId(1, 2, 0, 4'b0000, 'h15c), 9'b111_000_000, 4'b0010,
			hazardPkg::fwdNone, hazardPkg::fwdNone, 7'b1111111, 1'b0, 1'b0, 1'b0);
		addRow(makeId(0, 0, 0, 4'b0000, 'h160), 9'b111_000_000, 4'b0001,
			hazardPkg::fwdNone, hazardPkg::fwdNone, 7'b1111111, 1'b0, 1'b0, 1'b0);
		// Exception and eret over cache stalls
		addRow(makeId(0, 0, 0, 4'b0000, 'h164), 9'b101_001_000, 4'b1000,
			hazardPkg::fwdNone, hazardPkg::fwdNone, 7'b1111100, 1'b0, 1'b1, 1'b0, 1'b0);
		addRow(makeId(0, 0, 0, 4'b0000, 'h168), 9'b111_000_000, 4'b1000,
			hazardPkg::fwdNone, hazardPkg::fwdNone, 7'b1111111, 1'b0, 1'b0, 1'b0);
		addRow(makeId(0, 0, 0, 4'b0000, 'h16c), 9'b101_001_000, 4'b0100,
			hazardPkg::fwdNone, hazardPkg::fwdNone, 7'b1111100, 1'b0, 1'b1, 1'b0, 1'b0);
		addRow(makeId(0, 0, 0, 4'b0000, 'h170), 9'b111_001_000, 4'b0100,
			hazardPkg::fwdNone, hazardPkg::fwdNone, 7'b1111111, 1'b0, 1'b0, 1'b0);
		addRow(makeId(0, 0, 0, 4'b0000, 'h174), 9'b011_000_000, 4'b1000,
			hazardPkg::fwdNone, hazardPkg::fwdNone, 7'b1111111, 1'b0, 1'b1, 1'b0);
		addRow(makeId(0, 0, 0, 4'b0000, 'h178), 9'b111_000_000, 4'b0000,
			hazardPkg::fwdNone, hazardPkg::fwdNone, 7'b1111111, 1'b0, 1'b0, 1'b0);
	endtask

	initial begin
		wait (tableBuilt === 1'b1);
		#((rows.size() + 5 + 10) * 40);	// Rows plus reset plus slack, in clock periods
		$display("Timeout: the test sequence did not complete in time");
		$display("Checks failed");
		$finish;
	end

	initial begin
		testRow r;
		int failsBefore;
		clk = 1'b0;
		arstN = 1'b0;
		id = '0;
		status = 9'b111_000_000;
		evt = '0;
		passCount = 0;
		failCount = 0;
		tableBuilt = 1'b0;
		buildTable();
		tableBuilt = 1'b1;
		repeat (5) @(posedge clk);
		#5 arstN = 1'b1;
		for (int i = 0; i < rows.size(); i++) begin
			r = rows[i];
			failsBefore = failCount;
			@(posedge clk);
			#5;
			id = r.id;
			status = r.status;
			evt = r.evt;
			#30;	// Just before the next edge
			checkFwd("fwd", r.fwd, fwd);
			checkWrite("wr", r.wr, wr);
			checkBit("bubbleSel", r.bubbleSel, bubbleSel);
			checkBit("isStall", !r.wr.pcWr, isStall);
			checkBit("dcacheStall", r.dcacheStall, dcacheStall);
			checkBit("icacheStall", r.icacheStall, icacheStall);
			checkBit("dataOk", r.dataOk, dataOk);
			$display("Row %0d: %0d mismatches", i, failCount - failsBefore);
		end
		$display("Summary: %0d matched, %0d mismatched", passCount, failCount);
		if (failCount == 0) begin
			$display("All checks passed");
		end
		else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// ==== hazardCore_checker.sv ====
module hazardCoreChecker (
	input logic clk,
	input logic arstN,
	input hazardPkg::idInfo id,
	input hazardPkg::ctrlEvent evt,
	input hazardPkg::fwdSel fwd,
	input hazardPkg::stageWrite wr,
	input logic isStall,
	input logic dcacheStall
);

	logic flush;

	assign flush = evt.mem1Ex || evt.mem1EretFlush;	// Exception or eret in MEM1

	stallFollowsPc: assert property (
		@(posedge clk) disable iff (!arstN)
		isStall == !wr.pcWr
	)
	else $error("isStall is not the inverse of pcWr");

	// Cache stall freezes every boundary unless a flush takes over
	cacheFreeze: assert property (
		@(posedge clk) disable iff (!arstN)
		(dcacheStall && !flush) |-> (wr == '0)
	)
	else $error("dcacheStall left a write enable high");

	flushMovesPc: assert property (
		@(posedge clk) disable iff (!arstN)
		flush |-> wr.pcWr
	)
	else $error("pcWr low during exception or eret");

	zeroRsNoForward: assert property (
		@(posedge clk) disable iff (!arstN)
		(id.rs == '0) |-> (fwd.rsSel == hazardPkg::fwdNone)
	)
	else $error("rs of zero selected a forwarding source");

endmodule

// ==== hazardPkg.sv ====
package hazardPkg;

	localparam int regAddrW = 5;
	localparam int pcW = 32;

	// Operand source codes for the ID-stage operand muxes
	localparam logic [1:0] fwdNone = 2'b00;	// Register file
	localparam logic [1:0] fwdEx = 2'b01;
	localparam logic [1:0] fwdMem1 = 2'b10;
	localparam logic [1:0] fwdMem2 = 2'b11;

	// Decoded fields of the instruction sitting in ID
	typedef struct packed {
		logic [regAddrW-1:0] rs;
		logic [regAddrW-1:0] rt;
		logic [regAddrW-1:0] dest;
		logic rfWr;
		logic dmRd;
		logic cp0Rd;
		logic bjOp;	// Branch or jump compare in ID
		logic [pcW-1:0] pc;
	} idInfo;

	typedef struct packed {
		logic [regAddrW-1:0] rt;
		logic [regAddrW-1:0] dest;
		logic rfWr;
		logic dmRd;
		logic cp0Rd;
		logic [pcW-1:0] pc;
	} exTag;

	// Same fields as exTag for now, used by MEM1 and MEM2
	typedef struct packed {
		logic [regAddrW-1:0] rt;
		logic [regAddrW-1:0] dest;
		logic rfWr;
		logic dmRd;
		logic cp0Rd;
		logic [pcW-1:0] pc;
	} memTag;

	typedef struct packed {
		logic iCacheDataOk;
		logic dCacheDataOk;
		logic dCacheAddrOk;
		logic mem1CacheSel;	// Counts as address accepted
		logic mem1DCacheEn;
		logic mem2DCacheEn;
		logic mem1ValidExceptIcache;
		logic memLastStall;
		logic dcacheLastConflict;
	} cacheStatus;

	typedef struct packed {
		logic mem1Ex;
		logic mem1EretFlush;
		logic isBusy;	// Multiply/divide unit busy
		logic rhlVisit;	// ID reads or writes hi/lo
	} ctrlEvent;

	typedef struct packed {
		logic pcWr;
		logic pfIfWr;
		logic ifIdWr;
		logic idExWr;
		logic exMem1Wr;
		logic mem1Mem2Wr;
		logic mem2WbWr;
	} stageWrite;

	typedef struct packed {
		logic [1:0] rsSel;
		logic [1:0] rtSel;
	} fwdSel;

endpackage

// ==== stageReg.sv ====
module stageReg #(
	parameter type payloadT = hazardPkg::exTag
) (
	input logic clk,
	input logic arstN,
	input logic load,
	input logic bubble,
	input payloadT d,
	output payloadT q
);

	payloadT nextQ;

	// Bubble only takes effect together with load
	always_comb begin
		if (bubble)
			nextQ = '0;	// Empty slot, no writer
		else
			nextQ = d;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			q <= '0;
		end
		else if (load) begin
			q <= nextQ;
		end
	end

endmodule

// ==== stallUnit.sv ====
module stallUnit (
	input hazardPkg::idInfo id,
	input hazardPkg::exTag ex,
	input hazardPkg::memTag mem1,
	input hazardPkg::memTag mem2,
	input hazardPkg::cacheStatus status,
	input hazardPkg::ctrlEvent evt,
	output hazardPkg::stageWrite wr,
	output logic bubbleSel,
	output logic isStall,
	output logic dcacheStall,
	output logic icacheStall,
	output logic dataOk
);

	logic addrOk;
	logic conflict;
	logic exRtHit;
	logic mem1RtHit;
	logic mem2RtHit;
	logic exLoadUse;
	logic mem1LoadUse;
	logic mem2Branch;
	logic exBranch;
	logic dataHazard;
	logic mdStall;
	logic flush;

	assign exRtHit = (ex.rt == id.rs) || (ex.rt == id.rt);
	assign mem1RtHit = (mem1.rt == id.rs) || (mem1.rt == id.rt);
	assign mem2RtHit = (mem2.rt == id.rs) || (mem2.rt == id.rt);

	// Load or CP0 result not ready yet, pc compare skips the instruction itself
	assign exLoadUse = (ex.dmRd || ex.cp0Rd) && exRtHit && (ex.pc != id.pc);
	assign mem1LoadUse = (mem1.dmRd || mem1.cp0Rd) && mem1RtHit && (mem1.pc != id.pc);

	// Branch compares in ID and cannot take a late operand
	assign mem2Branch = id.bjOp && mem2.rfWr && mem2.dmRd && mem2RtHit;
	assign exBranch = id.bjOp && ex.rfWr && exRtHit;

	assign dataHazard = exLoadUse || mem1LoadUse || mem2Branch || exBranch;

	assign mdStall = evt.isBusy && evt.rhlVisit;	// Hi/lo access while busy
	assign flush = evt.mem1Ex || evt.mem1EretFlush;

	assign addrOk = status.mem1CacheSel || status.dCacheAddrOk;
	assign conflict = !status.mem1CacheSel && status.dcacheLastConflict;

	assign dataOk = status.dCacheDataOk || !status.mem2DCacheEn;

	assign dcacheStall = (!status.dCacheDataOk && status.mem2DCacheEn)
		|| (!addrOk && status.mem1DCacheEn)
		|| !status.iCacheDataOk;

	assign icacheStall = (status.memLastStall && status.mem2DCacheEn)
		|| (conflict && status.mem1ValidExceptIcache)
		|| mdStall
		|| dataHazard;

	always_comb begin
		wr = '1;
		bubbleSel = 1'b0;
		if (flush) begin
			// Back stages drain only when MEM2 data is in
			wr.mem1Mem2Wr = dataOk;
			wr.mem2WbWr = dataOk;
		end
		else if (dcacheStall) begin
			wr = '0;	// Freeze everything
			bubbleSel = 1'b1;
		end
		else if (mdStall || dataHazard) begin
			// Hold PC to ID, bubble into EX
			wr.pcWr = 1'b0;
			wr.pfIfWr = 1'b0;
			wr.ifIdWr = 1'b0;
			bubbleSel = 1'b1;
		end
	end

	assign isStall = !wr.pcWr;

endmodule
